// File: rtl/oq_macros.svh
`ifndef OQ_MACROS_SVH
`define OQ_MACROS_SVH

////////////////////////////////////////////////////////////
// stream widths
////////////////////////////////////////////////////////////

`define OQ_DATA_W           32
`define OQ_RANK_W           10
`define OQ_FLOW_W           6
// rank plus flow tag, or rank plus start address
`define OQ_SCHED_W          16

////////////////////////////////////////////////////////////
// packet buffer and calendar sizing
////////////////////////////////////////////////////////////

`define OQ_BUF_DEPTH        64
`define OQ_ADDR_W           6
// almost full once remaining space drops to one max packet
`define OQ_MAX_PKT_WORDS    8
`define OQ_CAL_DEPTH        8

`endif

// File: rtl/oq_stream_pkg.sv
`include "oq_macros.svh"

package oq_stream_pkg;

    typedef logic [`OQ_DATA_W-1:0] data_word_t;

    // scheduling word as it arrives from upstream
    typedef struct packed {
        logic [`OQ_RANK_W-1:0] rank;
        logic [`OQ_FLOW_W-1:0] flow;
    } sched_tag_t;

    // same word once the packet sits in the buffer
    typedef struct packed {
        logic [`OQ_RANK_W-1:0] rank;
        logic [`OQ_ADDR_W-1:0] addr;
    } sched_entry_t;

    typedef union packed {
        sched_tag_t   tag;
        sched_entry_t entry;
    } sched_word_u;

    // one buffer word
    typedef struct packed {
        data_word_t  data;
        logic        last;
        sched_word_u sched;
    } stream_word_t;

endpackage

// File: rtl/oq_buffer_pkg.sv
`include "oq_macros.svh"

package oq_buffer_pkg;

    // one buffer address
    typedef logic [`OQ_ADDR_W-1:0] buf_addr_t;

    // occupancy or remaining space needs one more bit than an address
    typedef logic [`OQ_ADDR_W:0] buf_count_t;

    // link table entry pointing at the next word of a packet or of the free list
    typedef buf_addr_t buf_link_t;

endpackage

// File: rtl/buf_rd_if.sv
`timescale 1ns/10ps

interface buf_rd_if;
    import oq_stream_pkg::*;
    import oq_buffer_pkg::*;

    logic         rd_en;
    buf_addr_t    rd_addr;
    // returned one cycle after rd_en
    logic         rd_valid;
    stream_word_t rd_word;
    buf_link_t    rd_next;

    modport reader
    (
        output rd_en,
        output rd_addr,
        input  rd_valid,
        input  rd_word,
        input  rd_next
    );

    modport store
    (
        input  rd_en,
        input  rd_addr,
        output rd_valid,
        output rd_word,
        output rd_next
    );

endinterface

// File: rtl/pkt_buffer.sv
`timescale 1ns/10ps
`include "oq_macros.svh"

module pkt_buffer
(
    input  logic                       axis_aclk,
    input  logic                       axis_resetn,
    input  oq_stream_pkg::data_word_t  in_data,
    input  oq_stream_pkg::sched_word_u in_sched,
    input  logic                       in_valid,
    input  logic                       in_last,
    buf_rd_if.store                    rd,
    output logic                       insert_en,
    output oq_stream_pkg::sched_word_u insert_entry,
    output oq_buffer_pkg::buf_count_t  remain_size,
    output oq_buffer_pkg::buf_count_t  word_count,
    output logic                       almost_full
);
    import oq_stream_pkg::*;
    import oq_buffer_pkg::*;

    stream_word_t mem [`OQ_BUF_DEPTH];
    buf_link_t    link_tbl [`OQ_BUF_DEPTH];
    buf_addr_t    fl_head;
    buf_addr_t    fl_tail;
    buf_addr_t    sop_addr;
    buf_addr_t    pkt_start;
    logic         in_pkt;
    buf_count_t   count_next;
    buf_count_t   remain_next;

    // first word of a packet takes the free head as its start
    assign pkt_start = in_pkt ? sop_addr : fl_head;

    ////////////////////////////////////////////////////////////
    // word memory and read port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (in_valid)
        begin
            mem[fl_head] <= '{data: in_data, last: in_last, sched: in_sched};
        end
        if (rd.rd_en)
        begin
            rd.rd_word <= mem[rd.rd_addr];
            rd.rd_next <= link_tbl[rd.rd_addr];
        end
    end

    ////////////////////////////////////////////////////////////
    // free list threaded through the link table
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            // every word free, chained in address order
            for (int i = 0; i < `OQ_BUF_DEPTH; i++)
            begin
                link_tbl[i] <= buf_link_t'(i + 1);
            end
            fl_head <= '0;
            fl_tail <= buf_addr_t'(`OQ_BUF_DEPTH - 1);
        end
        else
        begin
            // the written word keeps its link, which is the new free head
            if (in_valid)
                fl_head <= link_tbl[fl_head];
            // read word rejoins at the tail
            if (rd.rd_en)
            begin
                link_tbl[fl_tail] <= rd.rd_addr;
                fl_tail           <= rd.rd_addr;
            end
        end
    end

    // packet start and calendar entry
    always_ff @(posedge axis_aclk)
    begin
        if (in_valid)
        begin
            sop_addr                <= pkt_start;
            insert_entry.entry.rank <= in_sched.tag.rank;
            insert_entry.entry.addr <= pkt_start;
        end
    end

    ////////////////////////////////////////////////////////////
    // occupancy
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        count_next = word_count;
        if (in_valid && !rd.rd_en)
            count_next = word_count + 1'b1;
        else if (!in_valid && rd.rd_en)
            count_next = word_count - 1'b1;
    end

    assign remain_next = buf_count_t'(`OQ_BUF_DEPTH) - count_next;

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            in_pkt      <= 1'b0;
            insert_en   <= 1'b0;
            rd.rd_valid <= 1'b0;
            word_count  <= '0;
            remain_size <= buf_count_t'(`OQ_BUF_DEPTH);
            almost_full <= 1'b0;
        end
        else
        begin
            if (in_valid)
                in_pkt <= !in_last;
            insert_en   <= in_valid && in_last;
            rd.rd_valid <= rd.rd_en;
            word_count  <= count_next;
            remain_size <= remain_next;
            almost_full <= (remain_next <= buf_count_t'(`OQ_MAX_PKT_WORDS));
        end
    end

endmodule

// File: rtl/pifo_calendar.sv
`timescale 1ns/10ps
`include "oq_macros.svh"

module pifo_calendar
(
    input  logic                       axis_aclk,
    input  logic                       axis_resetn,
    input  logic                       insert_en,
    input  oq_stream_pkg::sched_word_u insert_entry,
    input  logic                       pop,
    output logic                       head_valid,
    output oq_stream_pkg::sched_word_u head_entry,
    output logic                       full
);
    import oq_stream_pkg::*;

    sched_word_u              slot [`OQ_CAL_DEPTH];
    logic [`OQ_CAL_DEPTH-1:0] valid;
    sched_word_u              cur_slot [`OQ_CAL_DEPTH];
    logic [`OQ_CAL_DEPTH-1:0] cur_valid;
    logic [`OQ_CAL_DEPTH-1:0] stay;
    sched_word_u              nxt_slot [`OQ_CAL_DEPTH];
    logic [`OQ_CAL_DEPTH-1:0] nxt_valid;

    always_comb
    begin
        // pop first, so egress always removes the head it saw
        for (int i = 0; i < `OQ_CAL_DEPTH - 1; i++)
        begin
            cur_slot[i] = pop ? slot[i + 1] : slot[i];
        end
        cur_slot[`OQ_CAL_DEPTH - 1] = slot[`OQ_CAL_DEPTH - 1];
        cur_valid = pop ? {1'b0, valid[`OQ_CAL_DEPTH-1:1]} : valid;

        // entries of equal or lower rank stay ahead of the new one
        for (int i = 0; i < `OQ_CAL_DEPTH; i++)
        begin
            stay[i] = cur_valid[i] && (cur_slot[i].entry.rank <= insert_entry.entry.rank);
        end

        nxt_slot[0]  = (insert_en && !stay[0]) ? insert_entry : cur_slot[0];
        nxt_valid[0] = cur_valid[0] || insert_en;
        for (int i = 1; i < `OQ_CAL_DEPTH; i++)
        begin
            if (!insert_en || stay[i])
                nxt_slot[i] = cur_slot[i];
            else if (stay[i - 1])
                nxt_slot[i] = insert_entry;
            else
                nxt_slot[i] = cur_slot[i - 1];
            nxt_valid[i] = cur_valid[i] || (insert_en && cur_valid[i - 1]);
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
            valid <= '0;
        else
            valid <= nxt_valid;
    end

    always_ff @(posedge axis_aclk)
    begin
        slot <= nxt_slot;
    end

    assign head_valid = valid[0];
    assign head_entry = slot[0];
    // last slot only fills when every slot is held
    assign full       = valid[`OQ_CAL_DEPTH - 1];

endmodule

// File: rtl/egress_scheduler.sv
`timescale 1ns/10ps

module egress_scheduler
(
    input  logic                       axis_aclk,
    input  logic                       axis_resetn,
    input  logic                       head_valid,
    input  oq_stream_pkg::sched_word_u head_entry,
    output logic                       pop,
    buf_rd_if.reader                   rd,
    output oq_stream_pkg::data_word_t  out_tdata,
    output oq_stream_pkg::sched_word_u out_tsched,
    output logic                       out_tvalid,
    output logic                       out_tlast,
    input  logic                       out_tready
);
    import oq_buffer_pkg::*;

    localparam logic [1:0] IDLE   = 2'd0;
    localparam logic [1:0] FETCH  = 2'd1;
    localparam logic [1:0] STREAM = 2'd2;

    logic [1:0] state;
    logic [1:0] state_next;
    buf_addr_t  start_addr;
    logic       stalled;
    logic       pend;
    logic       out_free;
    logic       load;

    // output register can take a word this cycle
    assign out_free = !out_tvalid || out_tready;
    // read data sits in the buffer output until moved
    assign pend     = rd.rd_valid || stalled;
    assign load     = (state == STREAM) && pend && out_free;

    ////////////////////////////////////////////////////////////
    // dequeue FSM
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        state_next = state;
        pop        = 1'b0;
        rd.rd_en   = 1'b0;
        rd.rd_addr = start_addr;
        case (state)
            IDLE:
            begin
                if (head_valid)
                begin
                    pop        = 1'b1;
                    state_next = FETCH;
                end
            end
            FETCH:
            begin
                if (out_free)
                begin
                    rd.rd_en   = 1'b1;
                    state_next = STREAM;
                end
            end
            STREAM:
            begin
                if (load)
                begin
                    if (rd.rd_word.last)
                    begin
                        state_next = IDLE;
                    end
                    else
                    begin
                        // follow the link of the word just moved
                        rd.rd_en   = 1'b1;
                        rd.rd_addr = rd.rd_next;
                    end
                end
            end
            default:
                state_next = IDLE;
        endcase
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            state      <= IDLE;
            stalled    <= 1'b0;
            out_tvalid <= 1'b0;
        end
        else
        begin
            state   <= state_next;
            stalled <= pend && !load;
            if (load)
                out_tvalid <= 1'b1;
            else if (out_tready)
                out_tvalid <= 1'b0;
        end
    end

    // start address and output payload
    always_ff @(posedge axis_aclk)
    begin
        if (pop)
            start_addr <= head_entry.entry.addr;
        if (load)
        begin
            out_tdata  <= rd.rd_word.data;
            out_tsched <= rd.rd_word.sched;
            out_tlast  <= rd.rd_word.last;
        end
    end

endmodule

// File: rtl/output_queue_top.sv
`timescale 1ns/10ps
`include "oq_macros.svh"

module output_queue_top
(
    input  logic                   axis_aclk,
    input  logic                   axis_resetn,
    input  logic [`OQ_DATA_W-1:0]  s_axis_tdata,
    input  logic [`OQ_SCHED_W-1:0] s_axis_tsched,
    input  logic                   s_axis_tvalid,
    input  logic                   s_axis_tlast,
    output logic [`OQ_DATA_W-1:0]  m_axis_tdata,
    output logic [`OQ_SCHED_W-1:0] m_axis_tsched,
    output logic                   m_axis_tvalid,
    output logic                   m_axis_tlast,
    input  logic                   m_axis_tready,
    output logic [`OQ_ADDR_W:0]    buffer_remain_size,
    output logic [`OQ_ADDR_W:0]    buffer_counter,
    output logic                   buffer_almost_full,
    output logic                   calendar_full
);
    import oq_stream_pkg::*;

    logic        insert_en;
    sched_word_u insert_entry;
    logic        head_valid;
    sched_word_u head_entry;
    logic        pop;

    buf_rd_if rd_bus ();

    // input side with the buffer write path and free list
    pkt_buffer i_pkt_buffer
    (
        .axis_aclk    (axis_aclk),
        .axis_resetn  (axis_resetn),
        .in_data      (s_axis_tdata),
        .in_sched     (s_axis_tsched),
        .in_valid     (s_axis_tvalid),
        .in_last      (s_axis_tlast),
        .rd           (rd_bus.store),
        .insert_en    (insert_en),
        .insert_entry (insert_entry),
        .remain_size  (buffer_remain_size),
        .word_count   (buffer_counter),
        .almost_full  (buffer_almost_full)
    );

    pifo_calendar i_pifo_calendar
    (
        .axis_aclk    (axis_aclk),
        .axis_resetn  (axis_resetn),
        .insert_en    (insert_en),
        .insert_entry (insert_entry),
        .pop          (pop),
        .head_valid   (head_valid),
        .head_entry   (head_entry),
        .full         (calendar_full)
    );

    // output side
    egress_scheduler i_egress_scheduler
    (
        .axis_aclk   (axis_aclk),
        .axis_resetn (axis_resetn),
        .head_valid  (head_valid),
        .head_entry  (head_entry),
        .pop         (pop),
        .rd          (rd_bus.reader),
        .out_tdata   (m_axis_tdata),
        .out_tsched  (m_axis_tsched),
        .out_tvalid  (m_axis_tvalid),
        .out_tlast   (m_axis_tlast),
        .out_tready  (m_axis_tready)
    );

endmodule

// File: verif/output_queue_assertions.sv
`timescale 1ns/10ps
`include "oq_macros.svh"

module output_queue_assertions
(
    input logic                   axis_aclk,
    input logic                   axis_resetn,
    input logic [`OQ_DATA_W-1:0]  m_axis_tdata,
    input logic [`OQ_SCHED_W-1:0] m_axis_tsched,
    input logic                   m_axis_tvalid,
    input logic                   m_axis_tlast,
    input logic                   m_axis_tready,
    input logic [`OQ_ADDR_W:0]    buffer_remain_size,
    input logic [`OQ_ADDR_W:0]    buffer_counter,
    input logic                   buffer_almost_full,
    input logic                   calendar_full
);

    int fail_count = 0;

    ////////////////////////////////////////////////////////////
    // reset values
    ////////////////////////////////////////////////////////////

    reset_values: assert property (@(posedge axis_aclk)
        $rose(axis_resetn) |-> !m_axis_tvalid && !buffer_almost_full && !calendar_full
            && buffer_counter == '0 && int'(buffer_remain_size) == `OQ_BUF_DEPTH)
    else
    begin
        fail_count++;
        $error("outputs not at their reset values after reset");
    end

    ////////////////////////////////////////////////////////////
    // output stream protocol
    ////////////////////////////////////////////////////////////

    hold_while_stalled: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata)
            && $stable(m_axis_tsched) && $stable(m_axis_tlast))
    else
    begin
        fail_count++;
        $error("output word changed or dropped while stalled");
    end

    known_when_valid: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        m_axis_tvalid |-> !$isunknown({m_axis_tdata, m_axis_tsched, m_axis_tlast}))
    else
    begin
        fail_count++;
        $error("output word has unknown bits while valid");
    end

endmodule

bind output_queue_top output_queue_assertions i_protocol_check (.*);

// File: verif/output_queue_tb.sv
`timescale 1ns/10ps
`include "oq_macros.svh"

module output_queue_tb;

    localparam int CLK_PERIOD = 100;
    // rank order 6, back-pressure 6, status up to 8, calendar full 10
    localparam int PKT_TOTAL  = 30;
    // few rank values so that ties occur
    localparam int RANK_BITS  = 2;
    localparam int LEN_BITS   = $clog2(`OQ_MAX_PKT_WORDS);

    logic                   axis_aclk;
    logic                   axis_resetn;
    logic [`OQ_DATA_W-1:0]  s_axis_tdata;
    logic [`OQ_SCHED_W-1:0] s_axis_tsched;
    logic                   s_axis_tvalid;
    logic                   s_axis_tlast;
    logic [`OQ_DATA_W-1:0]  m_axis_tdata;
    logic [`OQ_SCHED_W-1:0] m_axis_tsched;
    logic                   m_axis_tvalid;
    logic                   m_axis_tlast;
    logic                   m_axis_tready;
    logic [`OQ_ADDR_W:0]    buffer_remain_size;
    logic [`OQ_ADDR_W:0]    buffer_counter;
    logic                   buffer_almost_full;
    logic                   calendar_full;

    logic [16:0]            lfsr_state;
    int                     errors;
    int                     pkt_num;
    int                     words_sent;
    string                  test_name;
    // current burst in sending order
    int                     burst_id[$];
    int                     burst_len[$];
    logic [`OQ_SCHED_W-1:0] burst_sched[$];
    // expected leaving order
    int                     exp_id[$];
    int                     exp_len[$];
    logic [`OQ_SCHED_W-1:0] exp_sched[$];

    output_queue_top i_dut (.*);

    initial
    begin
        axis_aclk = 1'b0;
        forever
            #(CLK_PERIOD / 2) axis_aclk = ~axis_aclk;
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    // fibonacci lfsr with taps for x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    // packet number in the upper half, word index in the lower half
    function automatic logic [`OQ_DATA_W-1:0] payload(input int n, input int i);
        logic [`OQ_DATA_W/2-1:0] hi;
        logic [`OQ_DATA_W/2-1:0] lo;
        hi = n[`OQ_DATA_W/2-1:0];
        lo = i[`OQ_DATA_W/2-1:0];
        return {hi, lo};
    endfunction

    task automatic send_packet(input int len, input int rank);
        int                     flow;
        logic [`OQ_SCHED_W-1:0] sched;
        flow  = take_bits(`OQ_FLOW_W);
        sched = {rank[`OQ_RANK_W-1:0], flow[`OQ_FLOW_W-1:0]};
        for (int i = 0; i < len; i++)
        begin
            @(negedge axis_aclk);
            s_axis_tvalid = 1'b1;
            s_axis_tdata  = payload(pkt_num, i);
            s_axis_tsched = sched;
            s_axis_tlast  = (i == len - 1);
        end
        @(negedge axis_aclk);
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        burst_id.push_back(pkt_num);
        burst_len.push_back(len);
        burst_sched.push_back(sched);
        pkt_num++;
        words_sent += len;
    endtask

    task automatic random_burst(input int n);
        int len;
        for (int p = 0; p < n; p++)
        begin
            len = 1 + take_bits(LEN_BITS);
            // lead of two words or more keeps the egress busy with it alone
            if (p == 0 && len < 2)
                len = 2;
            send_packet(len, take_bits(RANK_BITS));
        end
    endtask

    // the lead is popped as soon as it reaches the calendar,
    // the rest leave by rank with ties in sending order
    task automatic order_burst();
        int best;
        exp_id.push_back(burst_id.pop_front());
        exp_len.push_back(burst_len.pop_front());
        exp_sched.push_back(burst_sched.pop_front());
        while (burst_id.size() > 0)
        begin
            best = 0;
            for (int k = 1; k < burst_id.size(); k++)
            begin
                if (burst_sched[k][`OQ_SCHED_W-1 -: `OQ_RANK_W]
                    < burst_sched[best][`OQ_SCHED_W-1 -: `OQ_RANK_W])
                    best = k;
            end
            exp_id.push_back(burst_id[best]);
            exp_len.push_back(burst_len[best]);
            exp_sched.push_back(burst_sched[best]);
            burst_id.delete(best);
            burst_len.delete(best);
            burst_sched.delete(best);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // output side checks
    ////////////////////////////////////////////////////////////

    task automatic drain(input int n, input bit toggle);
        int                    done_pkts;
        int                    word_i;
        logic [`OQ_DATA_W-1:0] exp_data;
        done_pkts = 0;
        word_i    = 0;
        while (done_pkts < n)
        begin
            @(negedge axis_aclk);
            m_axis_tready = toggle ? (take_bits(1) != 0) : 1'b1;
            // word is taken at the coming rising edge
            if (m_axis_tvalid && m_axis_tready)
            begin
                exp_data = payload(exp_id[0], word_i);
                assert (m_axis_tdata == exp_data)
                else
                begin
                    errors++;
                    $display("Mismatch %s data: expected %h, actual %h",
                             test_name, exp_data, m_axis_tdata);
                end
                assert (m_axis_tsched == exp_sched[0])
                else
                begin
                    errors++;
                    $display("Mismatch %s sched: expected %h, actual %h",
                             test_name, exp_sched[0], m_axis_tsched);
                end
                assert (m_axis_tlast == (word_i == exp_len[0] - 1))
                else
                begin
                    errors++;
                    $display("Mismatch %s last: expected %0d, actual %0d",
                             test_name, word_i == exp_len[0] - 1, m_axis_tlast);
                end
                if (word_i == exp_len[0] - 1)
                begin
                    void'(exp_id.pop_front());
                    void'(exp_len.pop_front());
                    void'(exp_sched.pop_front());
                    done_pkts++;
                    word_i = 0;
                end
                else
                    word_i++;
            end
        end
        @(negedge axis_aclk);
        m_axis_tready = 1'b0;
    endtask

    task automatic check_status(input int exp_count);
        assert (int'(buffer_counter) == exp_count)
        else
        begin
            errors++;
            $display("Mismatch %s buffer_counter: expected %0d, actual %0d",
                     test_name, exp_count, buffer_counter);
        end
        assert (int'(buffer_remain_size) == `OQ_BUF_DEPTH - exp_count)
        else
        begin
            errors++;
            $display("Mismatch %s buffer_remain_size: expected %0d, actual %0d",
                     test_name, `OQ_BUF_DEPTH - exp_count, buffer_remain_size);
        end
        assert (buffer_almost_full == (`OQ_BUF_DEPTH - exp_count <= `OQ_MAX_PKT_WORDS))
        else
        begin
            errors++;
            $display("Mismatch %s buffer_almost_full: expected %0d, actual %0d", test_name,
                     `OQ_BUF_DEPTH - exp_count <= `OQ_MAX_PKT_WORDS, buffer_almost_full);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        lfsr_state    = 17'd86940;
        errors        = 0;
        pkt_num       = 0;
        words_sent    = 0;
        test_name     = "reset";
        axis_resetn   = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tsched = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        m_axis_tready = 1'b0;
        repeat (3) @(negedge axis_aclk);
        axis_resetn = 1'b1;
        @(negedge axis_aclk);
        check_status(0);

        test_name = "rank_order";
        random_burst(6);
        order_burst();
        drain(6, 1'b0);

        test_name = "backpressure";
        random_burst(6);
        order_burst();
        drain(6, 1'b1);

        // fill with full-size packets until almost full
        test_name  = "status";
        words_sent = 0;
        while (!buffer_almost_full && burst_id.size() <= `OQ_CAL_DEPTH)
            send_packet(`OQ_MAX_PKT_WORDS, take_bits(RANK_BITS));
        while (!m_axis_tvalid)
            @(negedge axis_aclk);
        // lead word 0 sits in the output register with word 1 read behind it
        check_status(words_sent - 2);
        order_burst();
        drain(exp_id.size(), 1'b0);
        check_status(0);

        // egress holds two one-word packets, so ten fill the calendar
        test_name = "calendar_full";
        for (int p = 0; p < `OQ_CAL_DEPTH + 2; p++)
            send_packet(1, 0);
        @(negedge axis_aclk);
        assert (calendar_full)
        else
        begin
            errors++;
            $display("Mismatch %s calendar_full: expected 1, actual %0d",
                     test_name, calendar_full);
        end
        order_burst();
        drain(1, 1'b0);
        while (calendar_full)
            @(negedge axis_aclk);
        drain(`OQ_CAL_DEPTH + 1, 1'b0);
        check_status(0);

        $display("errors: %0d checks, %0d protocol assertions",
                 errors, i_dut.i_protocol_check.fail_count);
        if (errors == 0 && i_dut.i_protocol_check.fail_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // watchdog
    initial
    begin
        repeat (40 * PKT_TOTAL + 200) @(posedge axis_aclk);
        $display("timeout, the DUT stopped delivering packets in %s", test_name);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: build.f
+incdir+rtl
rtl/oq_stream_pkg.sv
rtl/oq_buffer_pkg.sv
rtl/buf_rd_if.sv
rtl/pkt_buffer.sv
rtl/pifo_calendar.sv
rtl/egress_scheduler.sv
rtl/output_queue_top.sv
verif/output_queue_assertions.sv
verif/output_queue_tb.sv
